// ==== cache_geom_pkg.sv ====
package cache_geom_pkg;

	// Cache organisation
	localparam int NUM_WAYS = 4;
	localparam int NUM_SETS = 128;
	localparam int AGE_W = 2;

	// Address split, tag down to byte offset
	localparam int ADDR_W = 32;
	localparam int TAG_W = 20;
	localparam int INDEX_W = 7;
	localparam int WORD_SEL_W = 3;
	localparam int BYTE_W = 2;

	// Data widths
	localparam int WORD_W = 32;
	localparam int WORDS_PER_LINE = 8;
	localparam int LINE_W = WORD_W * WORDS_PER_LINE;

	typedef struct packed {
		logic [TAG_W-1:0]      tag;
		logic [INDEX_W-1:0]    index;
		logic [WORD_SEL_W-1:0] word_sel;
		logic [BYTE_W-1:0]     byte_off;
	} addr_fields_t;

	// Same address word, either raw or split into fields
	typedef union packed {
		logic [ADDR_W-1:0] raw;
		addr_fields_t      f;
	} addr_u;

	// Word 0 sits in the low bits of the line
	typedef logic [WORDS_PER_LINE-1:0][WORD_W-1:0] line_t;

endpackage

// ==== cache_bus_pkg.sv ====
package cache_bus_pkg;

	import cache_geom_pkg::*;

	// One bit per way, used one-hot or as a valid mask
	typedef logic [NUM_WAYS-1:0] way_vec_t;

	// Address presented to all ways and the LRU in one cycle
	typedef struct packed {
		logic  valid;
		addr_u addr;
		logic  replay;
	} lookup_t;

	// Line write into the victim way, data travels beside it
	typedef struct packed {
		logic               valid;
		logic [INDEX_W-1:0] index;
		logic [TAG_W-1:0]   tag;
		way_vec_t           way;
	} fill_t;

	// Per-way compare result at the lookup index
	typedef struct packed {
		logic              hit;
		logic              valid;
		logic [WORD_W-1:0] word;
	} way_result_t;

endpackage

// ==== cache_way.sv ====
`timescale 1ns/1ps

module cache_way
	import cache_geom_pkg::*;
	import cache_bus_pkg::*;
#(
	parameter int WAY_ID = 0
) (
	input  logic        CLK,
	input  logic        RST,
	input  lookup_t     lookup,
	input  fill_t       fill,
	input  line_t       fill_line,
	output way_result_t result
);

	logic [TAG_W-1:0]    tag_mem  [NUM_SETS];
	logic [LINE_W-1:0]   line_mem [NUM_SETS];
	logic [NUM_SETS-1:0] valid_mem;

	logic [INDEX_W-1:0]  rd_index;
	logic                fill_sel;

	assign rd_index = lookup.addr.f.index;
	assign fill_sel = fill.valid && fill.way[WAY_ID];

	// Tag compare and word pick at the lookup index
	assign result.valid = valid_mem[rd_index];
	assign result.hit = lookup.valid && valid_mem[rd_index] &&
		(tag_mem[rd_index] == lookup.addr.f.tag);
	assign result.word = line_mem[rd_index][lookup.addr.f.word_sel * WORD_W +: WORD_W];

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			valid_mem <= '0;
		end else if (fill_sel) begin
			valid_mem[fill.index] <= 1'b1;
		end
	end

	// Tag and line follow the valid bit on the fill edge
	always_ff @(posedge CLK) begin
		if (fill_sel) begin
			tag_mem[fill.index] <= fill.tag;
			line_mem[fill.index] <= fill_line;
		end
	end

	// Fills only follow a miss, so no way may already hold the line
	a_no_dup_fill: assert property (@(posedge CLK) disable iff (!RST)
		fill.valid |-> !(valid_mem[fill.index] && (tag_mem[fill.index] == fill.tag)));

endmodule

// ==== cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl
	import cache_geom_pkg::*;
	import cache_bus_pkg::*;
(
	input  logic     CLK,
	input  logic     RST,
	input  logic     rd_en,
	input  addr_u    rd_addr,
	input  logic     mem_valid,
	input  logic     any_hit,
	input  way_vec_t victim,
	output lookup_t  lookup,
	output fill_t    fill,
	output addr_u    mem_addr,
	output logic     busy,
	output logic     fill_done
);

	addr_u held_addr;
	logic  miss;

	assign miss = rd_en && !any_hit;

	// New request wins, otherwise the held address is looked up
	always_comb begin
		lookup.valid = rd_en || fill_done;
		lookup.replay = !rd_en && fill_done;
		lookup.addr = rd_en ? rd_addr : held_addr;
	end

	// Line goes to the victim of the held set
	always_comb begin
		fill.valid = busy && mem_valid;
		fill.index = held_addr.f.index;
		fill.tag = held_addr.f.tag;
		fill.way = victim;
	end

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			busy <= 1'b0;
			fill_done <= 1'b0;
		end else begin
			fill_done <= fill.valid;
			if (miss) begin
				busy <= 1'b1;
			end else if (fill.valid) begin
				busy <= 1'b0;
			end
		end
	end

	// Missing address and its line address for memory
	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			held_addr <= '0;
			mem_addr <= '0;
		end else if (miss) begin
			held_addr <= rd_addr;
			mem_addr.f.tag <= rd_addr.f.tag;
			mem_addr.f.index <= rd_addr.f.index;
			mem_addr.f.word_sel <= '0;
			mem_addr.f.byte_off <= '0;
		end
	end

	// Only one miss may be outstanding
	a_no_rd_while_busy: assert property (@(posedge CLK) disable iff (!RST)
		rd_en |-> !busy);

	// Line written on the previous edge must be found by the replay
	a_replay_hits: assert property (@(posedge CLK) disable iff (!RST)
		lookup.valid && lookup.replay |-> any_hit);

endmodule

// ==== lru_state.sv ====
`timescale 1ns/1ps

module lru_state
	import cache_geom_pkg::*;
	import cache_bus_pkg::*;
(
	input  logic     CLK,
	input  logic     RST,
	input  lookup_t  lookup,
	input  way_vec_t hit_way,
	input  way_vec_t valid_vec,
	input  fill_t    fill,
	output way_vec_t victim
);

	logic [NUM_WAYS-1:0][AGE_W-1:0] age_mem [NUM_SETS];
	logic [NUM_WAYS-1:0][AGE_W-1:0] cur_ages;
	logic [NUM_WAYS-1:0][AGE_W-1:0] next_ages;
	logic [INDEX_W-1:0]             set_sel;
	way_vec_t                       upd_way;
	logic                           upd_en;
	logic [AGE_W-1:0]               old_age;
	logic [NUM_WAYS-1:0]            age_seen;
	logic                           found;

	// Fill and hit never share a cycle, so one read port is enough
	assign set_sel = fill.valid ? fill.index : lookup.addr.f.index;
	assign cur_ages = age_mem[set_sel];
	assign upd_en = fill.valid || (lookup.valid && |hit_way);
	assign upd_way = fill.valid ? fill.way : hit_way;

	// Used way becomes newest, ways that were newer age by one
	always_comb begin
		old_age = '0;
		for (int i = 0; i < NUM_WAYS; i++) begin
			if (upd_way[i]) begin
				old_age = old_age | cur_ages[i];
			end
		end
		for (int i = 0; i < NUM_WAYS; i++) begin
			if (upd_way[i]) begin
				next_ages[i] = '1;
			end else if (cur_ages[i] > old_age) begin
				next_ages[i] = cur_ages[i] - 1'b1;
			end else begin
				next_ages[i] = cur_ages[i];
			end
		end
	end

	// Lowest invalid way first, else the oldest one
	always_comb begin
		victim = '0;
		found = 1'b0;
		for (int i = 0; i < NUM_WAYS; i++) begin
			if (!valid_vec[i] && !found) begin
				victim[i] = 1'b1;
				found = 1'b1;
			end
		end
		if (!found) begin
			for (int i = 0; i < NUM_WAYS; i++) begin
				victim[i] = (cur_ages[i] == '0);
			end
		end
	end

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				for (int w = 0; w < NUM_WAYS; w++) begin
					age_mem[s][w] <= AGE_W'(w);
				end
			end
		end else if (upd_en) begin
			age_mem[set_sel] <= next_ages;
		end
	end

	always_comb begin
		age_seen = '0;
		for (int i = 0; i < NUM_WAYS; i++) begin
			age_seen[cur_ages[i]] = 1'b1;
		end
	end

	// Ages stay a permutation across all updates
	a_ages_distinct: assert property (@(posedge CLK) disable iff (!RST) &age_seen);

endmodule

// ==== hit_merge.sv ====
`timescale 1ns/1ps

module hit_merge
	import cache_geom_pkg::*;
	import cache_bus_pkg::*;
(
	input  logic                           CLK,
	input  logic                           RST,
	input  way_result_t [NUM_WAYS-1:0]     results,
	output way_vec_t                       hit_way,
	output logic                           any_hit,
	output way_vec_t                       valid_vec,
	output logic [WORD_W-1:0]              rd_data,
	output logic                           rd_hit
);

	logic [WORD_W-1:0] hit_word;

	// At most one way hits, so an OR of gated words selects it
	always_comb begin
		hit_word = '0;
		for (int i = 0; i < NUM_WAYS; i++) begin
			hit_way[i] = results[i].hit;
			valid_vec[i] = results[i].valid;
			if (results[i].hit) begin
				hit_word = hit_word | results[i].word;
			end
		end
	end

	assign any_hit = |hit_way;

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			rd_hit <= 1'b0;
		end else begin
			rd_hit <= any_hit;
		end
	end

	always_ff @(posedge CLK) begin
		if (any_hit) begin
			rd_data <= hit_word;
		end
	end

	a_one_hit: assert property (@(posedge CLK) disable iff (!RST) $onehot0(hit_way));

endmodule

// ==== icache_top.sv ====
`timescale 1ns/1ps

module icache_top
	import cache_geom_pkg::*;
	import cache_bus_pkg::*;
(
	input  logic              CLK,
	input  logic              RST,
	input  logic              rd_en,
	input  addr_u             rd_addr,
	input  logic              mem_valid,
	input  line_t             mem_line,
	output logic [WORD_W-1:0] rd_data,
	output logic              rd_hit,
	output addr_u             mem_addr,
	output logic              busy,
	output logic              fill_done
);

	lookup_t                    lookup;
	fill_t                      fill;
	way_result_t [NUM_WAYS-1:0] results;
	way_vec_t                   hit_way;
	way_vec_t                   valid_vec;
	way_vec_t                   victim;
	logic                       any_hit;

	cache_ctrl u_ctrl (
		.CLK       (CLK),
		.RST       (RST),
		.rd_en     (rd_en),
		.rd_addr   (rd_addr),
		.mem_valid (mem_valid),
		.any_hit   (any_hit),
		.victim    (victim),
		.lookup    (lookup),
		.fill      (fill),
		.mem_addr  (mem_addr),
		.busy      (busy),
		.fill_done (fill_done)
	);

	// Memory line is written straight into the selected way
	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
		cache_way #(
			.WAY_ID (w)
		) u_way (
			.CLK       (CLK),
			.RST       (RST),
			.lookup    (lookup),
			.fill      (fill),
			.fill_line (mem_line),
			.result    (results[w])
		);
	end

	hit_merge u_merge (
		.CLK       (CLK),
		.RST       (RST),
		.results   (results),
		.hit_way   (hit_way),
		.any_hit   (any_hit),
		.valid_vec (valid_vec),
		.rd_data   (rd_data),
		.rd_hit    (rd_hit)
	);

	lru_state u_lru (
		.CLK       (CLK),
		.RST       (RST),
		.lookup    (lookup),
		.hit_way   (hit_way),
		.valid_vec (valid_vec),
		.fill      (fill),
		.victim    (victim)
	);

endmodule

// ==== tb_icache.sv ====
`timescale 1ns/1ps

module tb_icache
	import cache_geom_pkg::*;
();

	localparam int TIMEOUT = 50;
	localparam int RAND_READS = 200;

	logic              CLK;
	logic              RST;
	logic              rd_en;
	addr_u             rd_addr;
	logic              mem_valid;
	line_t             mem_line;
	logic [WORD_W-1:0] rd_data;
	logic              rd_hit;
	addr_u             mem_addr;
	logic              busy;
	logic              fill_done;

	// Expected tag store and ages
	logic [TAG_W-1:0] ref_tag   [NUM_SETS][NUM_WAYS];
	logic             ref_valid [NUM_SETS][NUM_WAYS];
	int               ref_age   [NUM_SETS][NUM_WAYS];

	logic [31:0] rng;
	int          err_count;
	int          test_errs;
	int          tests_run;
	int          tests_bad;

	icache_top DUT (
		.CLK       (CLK),
		.RST       (RST),
		.rd_en     (rd_en),
		.rd_addr   (rd_addr),
		.mem_valid (mem_valid),
		.mem_line  (mem_line),
		.rd_data   (rd_data),
		.rd_hit    (rd_hit),
		.mem_addr  (mem_addr),
		.busy      (busy),
		.fill_done (fill_done)
	);

	always #2 CLK = ~CLK;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] make_addr(input logic [TAG_W-1:0] tag,
		input logic [INDEX_W-1:0] index, input logic [WORD_SEL_W-1:0] word_sel);
		addr_u a;
		a.f.tag = tag;
		a.f.index = index;
		a.f.word_sel = word_sel;
		a.f.byte_off = '0;
		return a.raw;
	endfunction

	// Way holding the address in the expected store, -1 on a miss
	function automatic int ref_lookup(input addr_u a);
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (ref_valid[a.f.index][w] && ref_tag[a.f.index][w] == a.f.tag) begin
				return w;
			end
		end
		return -1;
	endfunction

	function automatic int ref_victim(input logic [INDEX_W-1:0] idx);
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (!ref_valid[idx][w]) begin
				return w;
			end
		end
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (ref_age[idx][w] == 0) begin
				return w;
			end
		end
		return 0;
	endfunction

	// Used way becomes age 3, newer ways step down
	task automatic ref_touch(input logic [INDEX_W-1:0] idx, input int way);
		int old;
		old = ref_age[idx][way];
		for (int i = 0; i < NUM_WAYS; i++) begin
			if (i == way) begin
				ref_age[idx][i] = 3;
			end else if (ref_age[idx][i] > old) begin
				ref_age[idx][i] = ref_age[idx][i] - 1;
			end
		end
	endtask

	task automatic next_cycle();
		@(posedge CLK);
		#1;
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Fail %s got %h expected %h at %0t", name, got, exp, $time);
			err_count++;
		end
	endtask

	task automatic abort_run(input string what);
		$display("Timeout while waiting for %s at %0t", what, $time);
		$display("Some tests failed");
		$finish;
	endtask

	task automatic wait_fill_done();
		int n;
		n = 0;
		while (!fill_done && n < TIMEOUT) begin
			next_cycle();
			n++;
		end
		if (!fill_done) begin
			abort_run("fill_done");
		end
	endtask

	task automatic wait_rd_hit();
		int n;
		n = 0;
		while (!rd_hit && n < TIMEOUT) begin
			next_cycle();
			n++;
		end
		if (!rd_hit) begin
			abort_run("rd_hit after the fill");
		end
	endtask

	// Memory answers a few cycles late, word k is line address plus k
	task automatic serve_memory();
		int lat;
		rng = xorshift32(rng);
		lat = 1 + int'(rng % 4);
		repeat (lat) next_cycle();
		for (int k = 0; k < WORDS_PER_LINE; k++) begin
			mem_line[k] = mem_addr.raw + 32'(k);
		end
		mem_valid = 1'b1;
		next_cycle();
		mem_valid = 1'b0;
	endtask

	// One read, checked against the expected store, fill served on a miss
	task automatic read_check(input logic [31:0] addr, output logic was_hit);
		addr_u       a;
		int          way;
		logic [31:0] line_addr;
		logic [31:0] exp_word;
		a.raw = addr;
		way = ref_lookup(a);
		line_addr = addr & 32'hFFFF_FFE0;
		exp_word = line_addr + 32'(a.f.word_sel);
		rd_addr = a;
		rd_en = 1'b1;
		next_cycle();
		rd_en = 1'b0;
		was_hit = rd_hit;
		check_val("rd_hit", 32'(rd_hit), 32'(way >= 0));
		if (rd_hit) begin
			check_val("rd_data", rd_data, exp_word);
		end else begin
			assert (busy) else begin
				$display("Read of %h neither hit nor started a fill", addr);
				err_count++;
			end
			if (busy) begin
				check_val("mem_addr", mem_addr.raw, line_addr);
				serve_memory();
				wait_fill_done();
				check_val("busy", 32'(busy), 32'h0);
				wait_rd_hit();
				check_val("rd_data", rd_data, exp_word);
				// Fill strobe lasts a single cycle
				check_val("fill_done", 32'(fill_done), 32'h0);
			end
		end
		if (way < 0) begin
			way = ref_victim(a.f.index);
			ref_tag[a.f.index][way] = a.f.tag;
			ref_valid[a.f.index][way] = 1'b1;
		end
		ref_touch(a.f.index, way);
	endtask

	task automatic read_expect(input logic [31:0] addr, input logic exp_hit);
		logic hit;
		read_check(addr, hit);
		check_val("rd_hit", 32'(hit), 32'(exp_hit));
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (err_count != test_errs) begin
			tests_bad++;
			$display("Test %s: %0d errors", name, err_count - test_errs);
		end else begin
			$display("Test %s: ok", name);
		end
		test_errs = err_count;
	endtask

	task automatic test_first_miss();
		check_val("rd_hit", 32'(rd_hit), 32'h0);
		check_val("busy", 32'(busy), 32'h0);
		check_val("fill_done", 32'(fill_done), 32'h0);
		read_expect(32'h1234_5644, 1'b0);
		// Replay strobe must not repeat
		next_cycle();
		check_val("rd_hit", 32'(rd_hit), 32'h0);
		finish_test("first_miss");
	endtask

	task automatic test_line_words();
		for (int w = 0; w < WORDS_PER_LINE; w++) begin
			read_expect(32'h1234_5640 + 32'(4 * w), 1'b1);
		end
		finish_test("line_words");
	endtask

	task automatic test_fill_order();
		for (int r = 0; r < 2; r++) begin
			for (int t = 0; t < NUM_WAYS; t++) begin
				read_expect(make_addr(TAG_W'(32'hA0000 + t), 7'd5, 3'd2), r == 1);
			end
		end
		finish_test("fill_order");
	endtask

	task automatic test_lru_evict();
		int order[4] = '{1, 0, 3, 2};
		for (int t = 0; t < NUM_WAYS; t++) begin
			read_expect(make_addr(TAG_W'(32'hB0000 + t), 7'd9, 3'd0), 1'b0);
		end
		for (int i = 0; i < NUM_WAYS; i++) begin
			read_expect(make_addr(TAG_W'(32'hB0000 + order[i]), 7'd9, 3'd1), 1'b1);
		end
		// Tag 1 was used longest ago
		read_expect(make_addr(TAG_W'(32'hB0004), 7'd9, 3'd3), 1'b0);
		read_expect(make_addr(TAG_W'(32'hB0000), 7'd9, 3'd4), 1'b1);
		read_expect(make_addr(TAG_W'(32'hB0002), 7'd9, 3'd5), 1'b1);
		read_expect(make_addr(TAG_W'(32'hB0003), 7'd9, 3'd6), 1'b1);
		read_expect(make_addr(TAG_W'(32'hB0001), 7'd9, 3'd7), 1'b0);
		finish_test("lru_evict");
	endtask

	task automatic test_random_reads();
		logic [31:0] addr;
		logic        hit;
		for (int i = 0; i < RAND_READS; i++) begin
			rng = xorshift32(rng);
			addr = make_addr(TAG_W'(32'h300 + rng % 6), INDEX_W'(20 + (rng >> 8) % 3),
				rng[18:16]);
			read_check(addr, hit);
		end
		finish_test("random_reads");
	endtask

	initial begin
		CLK = 1'b0;
		RST = 1'b0;
		rd_en = 1'b0;
		rd_addr = '0;
		mem_valid = 1'b0;
		mem_line = '0;
		rng = 32'd70;
		err_count = 0;
		test_errs = 0;
		tests_run = 0;
		tests_bad = 0;
		for (int s = 0; s < NUM_SETS; s++) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				ref_tag[s][w] = '0;
				ref_valid[s][w] = 1'b0;
				ref_age[s][w] = w;
			end
		end
		repeat (3) @(posedge CLK);
		#1;
		RST = 1'b1;
		next_cycle();
		test_first_miss();
		test_line_words();
		test_fill_order();
		test_lru_evict();
		test_random_reads();
		$display("Tests run %0d, tests with errors %0d, check errors %0d",
			tests_run, tests_bad, err_count);
		if (err_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// ==== sim.f ====
cache_geom_pkg.sv
cache_bus_pkg.sv
cache_way.sv
cache_ctrl.sv
lru_state.sv
hit_merge.sv
icache_top.sv
tb_icache.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_icache
RTL_TOP ?= icache_top
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Some tests failed" $(LOG); then exit 1; fi
	@if ! grep -q "All tests passed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
